// ==== dv/tb_sprite_line_eval.sv ====
`timescale 1ns/100ps

/*
  table driven testbench for the sprite line evaluation top level
  attribute sets are reloaded only when a row asks for a different set
  hit list addresses past the terminator are never read back
*/
module tb_sprite_line_eval;

    localparam int sprites_total = 48;
    localparam int hit_list_size = 32;
    localparam int n_rows = 7;
    localparam int timeout_cycles = n_rows * (sprites_total + hit_list_size + 40) + 100;
    localparam int set_random = 0;
    localparam int set_overflow = 1;
    localparam int set_wrap = 2;

    logic clk;
    logic rst;
    logic attr_wr_en;
    logic [7:0] attr_wr_addr;
    logic [8:0] attr_wr_y;
    logic [4:0] attr_wr_height;
    logic attr_wr_width;
    logic attr_wr_flip;
    logic line_start;
    logic [8:0] line_y;
    logic [8:0] hit_rd_addr;
    logic busy;
    logic line_done;
    logic [8:0] hit_count;
    logic [7:0] hit_rd_id;
    logic [3:0] hit_rd_row;
    logic hit_rd_width;
    logic hit_rd_terminator;

    // test table
    string row_name [n_rows];
    int row_set [n_rows];
    int row_y [n_rows];
    bit row_extra [n_rows];

    // local copy of the attribute table
    int mir_y [sprites_total];
    int mir_h [sprites_total];
    int mir_w [sprites_total];
    int mir_f [sprites_total];

    logic [13:0] exp_entry [hit_list_size];
    int exp_count;
    logic [31:0] lcg_state;
    int loaded_set;
    int cycle_count;
    int done_count;
    int test_errors;
    int error_count;
    int pass_count;
    int fail_count;

    sprite_line_eval_top #(
        .sprites_total(sprites_total),
        .hit_list_size(hit_list_size)
    ) i_dut (
        .clk(clk),
        .rst(rst),
        .attr_wr_en(attr_wr_en),
        .attr_wr_addr(attr_wr_addr),
        .attr_wr_y(attr_wr_y),
        .attr_wr_height(attr_wr_height),
        .attr_wr_width(attr_wr_width),
        .attr_wr_flip(attr_wr_flip),
        .line_start(line_start),
        .line_y(line_y),
        .hit_rd_addr(hit_rd_addr),
        .busy(busy),
        .line_done(line_done),
        .hit_count(hit_count),
        .hit_rd_id(hit_rd_id),
        .hit_rd_row(hit_rd_row),
        .hit_rd_width(hit_rd_width),
        .hit_rd_terminator(hit_rd_terminator)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= timeout_cycles) begin
            $display("timeout after %0d cycles, the tests did not complete", cycle_count);
            $display("sim failed");
            $finish;
        end
    end

    // counts every line_done pulse
    always @(posedge clk) begin
        if (rst) begin
            done_count <= 0;
        end else if (line_done) begin
            done_count <= done_count + 1;
        end
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return {17'd0, lcg_state[30:16]};
    endfunction

    task automatic set_row(input int r, input string name, input int set_sel, input int y,
                           input bit extra);
        row_name[r] = name;
        row_set[r] = set_sel;
        row_y[r] = y;
        row_extra[r] = extra;
    endtask

    task automatic write_attr(input int id, input int y, input int h, input int w, input int f);
        attr_wr_en = 1'b1;
        attr_wr_addr = 8'(id);
        attr_wr_y = 9'(y);
        attr_wr_height = 5'(h);
        attr_wr_width = 1'(w);
        attr_wr_flip = 1'(f);
        mir_y[id] = y;
        mir_h[id] = h;
        mir_w[id] = w;
        mir_f[id] = f;
        @(posedge clk);
        #1;
        attr_wr_en = 1'b0;
    endtask

    task automatic load_set(input int set_sel);
        int y;
        int h;
        int bits;
        for (int id = 0; id < sprites_total; id++) begin
            if (set_sel == set_overflow) begin
                // first 40 sprites all cross line 105
                y = (id < 40) ? 100 : 400;
                h = (id < 40) ? 16 : 4;
                bits = id % 4;
            end else begin
                y = int'(lcg_next() % 64);
                h = 1 + int'(lcg_next() % 16);
                bits = int'(lcg_next() % 4);
            end
            if (set_sel == set_random && id == 0) begin
                y = 16;
                h = 16;
                bits = 3;
            end
            if (set_sel == set_random && id == sprites_total - 1) begin
                y = 20;
                h = 16;
                bits = 0;
            end
            // sprites near the bottom that wrap past line 0
            if (set_sel == set_wrap && id == 5) begin
                y = 505;
                h = 16;
                bits = 0;
            end
            if (set_sel == set_wrap && id == 6) begin
                y = 510;
                h = 8;
                bits = 3;
            end
            if (set_sel == set_wrap && id == 7) begin
                y = 500;
                h = 12;
                bits = 1;
            end
            write_attr(id, y, h, bits % 2, bits / 2);
        end
    endtask

    // reference model of the hit list for one raster line
    task automatic build_expected(input int ry);
        int diff;
        int row;
        int total;
        total = 0;
        for (int id = 0; id < sprites_total; id++) begin
            diff = (ry - mir_y[id] + 512) % 512;
            if (diff < mir_h[id]) begin
                row = (mir_f[id] != 0) ? mir_h[id] - 1 - diff : diff;
                if (total < hit_list_size) begin
                    exp_entry[total] = {8'(id), 4'(row), 1'(mir_w[id]), 1'b0};
                end
                total++;
            end
        end
        exp_count = (total < hit_list_size) ? total : hit_list_size;
    endtask

    task automatic run_row(input int r);
        int start_done;
        logic [13:0] expected;
        logic [13:0] actual;
        test_errors = 0;
        if (row_set[r] != loaded_set) begin
            load_set(row_set[r]);
            loaded_set = row_set[r];
        end
        build_expected(row_y[r]);
        start_done = done_count;
        line_y = 9'(row_y[r]);
        line_start = 1'b1;
        @(posedge clk);
        #1;
        line_start = 1'b0;
        if (row_extra[r]) begin
            repeat (5) begin
                @(posedge clk);
                #1;
            end
            if (busy !== 1'b1) begin
                $display("ERR %s busy expected 1 actual %b", row_name[r], busy);
                test_errors++;
            end
            line_y = 9'd300;
            line_start = 1'b1;
            @(posedge clk);
            #1;
            line_start = 1'b0;
        end
        while (!line_done) begin
            @(posedge clk);
            #1;
        end
        if (hit_count !== 9'(exp_count)) begin
            $display("ERR %s hit_count expected %0d actual %0d", row_name[r], exp_count,
                     hit_count);
            test_errors++;
        end
        // entries, then the terminator when the list is not full
        for (int a = 0; a <= exp_count && a < hit_list_size; a++) begin
            hit_rd_addr = 9'(a);
            @(posedge clk);
            #1;
            actual = {hit_rd_id, hit_rd_row, hit_rd_width, hit_rd_terminator};
            expected = (a < exp_count) ? exp_entry[a] : {8'd0, 4'd0, 1'b0, 1'b1};
            if (actual !== expected) begin
                $display("ERR %s entry %0d expected %h actual %h", row_name[r], a,
                         expected, actual);
                test_errors++;
            end
        end
        if (row_extra[r]) begin
            repeat (sprites_total + 10) begin
                @(posedge clk);
                #1;
            end
            if (done_count - start_done != 1) begin
                $display("ERR %s line_done pulses expected 1 actual %0d", row_name[r],
                         done_count - start_done);
                test_errors++;
            end
        end
        if (test_errors == 0) begin
            pass_count++;
            $display("PASS %s with %0d hits", row_name[r], exp_count);
        end else begin
            fail_count++;
            $display("FAIL %s with %0d errors", row_name[r], test_errors);
        end
        error_count += test_errors;
    endtask

    initial begin
        rst = 1'b1;
        attr_wr_en = 1'b0;
        attr_wr_addr = '0;
        attr_wr_y = '0;
        attr_wr_height = '0;
        attr_wr_width = 1'b0;
        attr_wr_flip = 1'b0;
        line_start = 1'b0;
        line_y = '0;
        hit_rd_addr = '0;
        lcg_state = 32'd84;
        loaded_set = -1;
        cycle_count = 0;
        error_count = 0;
        pass_count = 0;
        fail_count = 0;

        // the empty line follows a line whose first hit is sprite 0
        set_row(0, "random_line_20", set_random, 20, 1'b0);
        set_row(1, "empty_line_300", set_random, 300, 1'b0);
        set_row(2, "random_line_45", set_random, 45, 1'b0);
        set_row(3, "random_line_70", set_random, 70, 1'b0);
        set_row(4, "start_while_busy", set_random, 33, 1'b1);
        set_row(5, "wrap_line_3", set_wrap, 3, 1'b0);
        set_row(6, "overflow_line_105", set_overflow, 105, 1'b0);

        repeat (5) @(posedge clk);
        #1;
        rst = 1'b0;

        if (busy !== 1'b0 || line_done !== 1'b0 || hit_count !== 9'd0) begin
            $display("ERR reset_state busy/done/count expected 0/0/0 actual %b/%b/%0d",
                     busy, line_done, hit_count);
            error_count++;
            fail_count++;
            $display("FAIL reset_state");
        end else begin
            pass_count++;
            $display("PASS reset_state");
        end

        for (int r = 0; r < n_rows; r++) begin
            run_row(r);
        end

        $display("tests %0d, passed %0d, failed %0d, errors %0d", pass_count + fail_count,
                 pass_count, fail_count, error_count);
        if (error_count == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

// ==== rtl/hit_list_if.sv ====
`timescale 1ns/100ps

/*
  hit list write path from the scanner to the hit list memory
  entry is stored at index in the cycle write_en is high
  no handshake, the memory always accepts
*/
interface hit_list_if;

    logic write_en;
    logic [sprite_eval_pkg::hit_index_w-1:0] index;
    sprite_eval_pkg::hit_entry_t entry;

    modport scanner (
        output write_en,
        output index,
        output entry
    );

    modport memory (
        input  write_en,
        input  index,
        input  entry
    );

endinterface

// ==== rtl/line_eval_ctrl.sv ====
`timescale 1ns/100ps

/*
  accepts a line start, holds the raster y and restarts the scanner
  a line start while busy is dropped, not queued
  hit_count holds from line_done until the next accepted start
*/
module line_eval_ctrl (
    input  logic clk,
    input  logic rst,
    input  logic line_start,
    input  logic [sprite_eval_pkg::raster_y_w-1:0] line_y,
    output logic restart,
    output logic [sprite_eval_pkg::raster_y_w-1:0] raster_y,
    input  logic finished,
    input  logic [sprite_eval_pkg::hit_index_w-1:0] scan_hit_count,
    output logic busy,
    output logic line_done,
    output logic [sprite_eval_pkg::hit_index_w-1:0] hit_count
);

    typedef enum logic [1:0] {
        st_idle,
        st_scan,
        st_done
    } state_t;

    state_t state;
    logic finished_q;
    logic accept;
    logic finish_edge;

    assign accept = line_start && (state != st_scan);
    assign finish_edge = finished && !finished_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= st_idle;
            restart <= 1'b0;
            finished_q <= 1'b0;
            hit_count <= '0;
        end else begin
            restart <= 1'b0;
            finished_q <= finished;
            case (state)
                st_scan: begin
                    if (finish_edge) begin
                        state <= st_done;
                        hit_count <= scan_hit_count;
                    end
                end
                default: begin
                    // idle and done both take a new line
                    if (accept) begin
                        state <= st_scan;
                        restart <= 1'b1;
                    end else begin
                        state <= st_idle;
                    end
                end
            endcase
        end
    end

    // raster y stays put for the whole scan
    always_ff @(posedge clk) begin
        if (accept) begin
            raster_y <= line_y;
        end
    end

    assign busy = (state == st_scan);
    assign line_done = (state == st_done);

endmodule

// ==== rtl/sprite_attr_if.sv ====
`timescale 1ns/100ps

/*
  attribute table read path between the scanner and the table memory
  attr shows the entry for test_id one cycle after test_id is presented
*/
interface sprite_attr_if;

    // sprite whose attributes are requested
    logic [sprite_eval_pkg::sprite_id_w-1:0] test_id;

    // registered read data from the table
    sprite_eval_pkg::sprite_attr_t attr;

    modport scanner (
        output test_id,
        input  attr
    );

    // table side, named attr_table since table is a reserved word
    modport attr_table (
        input  test_id,
        output attr
    );

endinterface

// ==== rtl/sprite_eval_pkg.sv ====
/*
  shared widths and types of the sprite evaluation stage
  raster y and sprite y wrap in a 512 line space
  sprite heights outside 1 to 16 are not legal
*/
package sprite_eval_pkg;

    localparam int raster_y_w = 9;
    localparam int sprite_id_w = 8;

    // one extra bit so a full 256 entry list can be counted
    localparam int hit_index_w = 9;

    typedef logic [4:0] sprite_height_t;
    typedef logic [3:0] sprite_row_t;

    // attribute table entry, 16 bits
    typedef struct packed {
        logic [raster_y_w-1:0] y;
        sprite_height_t height;
        logic width_select;
        logic flip_y;
    } sprite_attr_t;

    // hit list entry, 14 bits
    typedef struct packed {
        logic [sprite_id_w-1:0] sprite_id;
        sprite_row_t row;
        logic width_select;
        logic terminator;
    } hit_entry_t;

    // closes the list, all other fields zero
    localparam hit_entry_t hit_terminator = '{
        sprite_id: '0,
        row: '0,
        width_select: 1'b0,
        terminator: 1'b1
    };

endpackage

// ==== rtl/sprite_line_eval_top.sv ====
`timescale 1ns/100ps

/*
  sprite evaluation for one scanline, attribute table and hit list inside
  attribute writes above sprites_total-1 and hit reads above hit_list_size-1
  are out of range, line start is ignored while busy
*/
module sprite_line_eval_top #(
    parameter int sprites_total = 48,
    parameter int hit_list_size = 32
) (
    input  logic clk,
    input  logic rst,
    input  logic attr_wr_en,
    input  logic [sprite_eval_pkg::sprite_id_w-1:0] attr_wr_addr,
    input  logic [sprite_eval_pkg::raster_y_w-1:0] attr_wr_y,
    input  sprite_eval_pkg::sprite_height_t attr_wr_height,
    input  logic attr_wr_width,
    input  logic attr_wr_flip,
    input  logic line_start,
    input  logic [sprite_eval_pkg::raster_y_w-1:0] line_y,
    input  logic [sprite_eval_pkg::hit_index_w-1:0] hit_rd_addr,
    output logic busy,
    output logic line_done,
    output logic [sprite_eval_pkg::hit_index_w-1:0] hit_count,
    output logic [sprite_eval_pkg::sprite_id_w-1:0] hit_rd_id,
    output sprite_eval_pkg::sprite_row_t hit_rd_row,
    output logic hit_rd_width,
    output logic hit_rd_terminator
);

    localparam int attr_addr_w = (sprites_total > 1) ? $clog2(sprites_total) : 1;
    localparam int hit_addr_w = (hit_list_size > 1) ? $clog2(hit_list_size) : 1;

    sprite_attr_if attr_bus ();
    hit_list_if hit_bus ();

    logic restart;
    logic finished;
    logic [sprite_eval_pkg::raster_y_w-1:0] raster_y;
    logic [sprite_eval_pkg::hit_index_w-1:0] scan_hit_count;
    sprite_eval_pkg::sprite_attr_t attr_wr_data;
    sprite_eval_pkg::hit_entry_t hit_rd_entry;

    always_comb begin
        attr_wr_data.y = attr_wr_y;
        attr_wr_data.height = attr_wr_height;
        attr_wr_data.width_select = attr_wr_width;
        attr_wr_data.flip_y = attr_wr_flip;
    end

    line_eval_ctrl i_ctrl (
        .clk(clk),
        .rst(rst),
        .line_start(line_start),
        .line_y(line_y),
        .restart(restart),
        .raster_y(raster_y),
        .finished(finished),
        .scan_hit_count(scan_hit_count),
        .busy(busy),
        .line_done(line_done),
        .hit_count(hit_count)
    );

    sprite_raster_collision #(
        .sprites_total(sprites_total),
        .hit_list_size(hit_list_size)
    ) i_scanner (
        .clk(clk),
        .rst(rst),
        .restart(restart),
        .raster_y(raster_y),
        .attr(attr_bus.scanner),
        .hits(hit_bus.scanner),
        .finished(finished),
        .hit_count(scan_hit_count)
    );

    sprite_table_ram #(
        .entry_t(sprite_eval_pkg::sprite_attr_t),
        .depth(sprites_total)
    ) i_attr_table (
        .clk(clk),
        .wr_en(attr_wr_en),
        .wr_addr(attr_wr_addr[attr_addr_w-1:0]),
        .wr_data(attr_wr_data),
        .rd_addr(attr_bus.test_id[attr_addr_w-1:0]),
        .rd_data(attr_bus.attr)
    );

    sprite_table_ram #(
        .entry_t(sprite_eval_pkg::hit_entry_t),
        .depth(hit_list_size)
    ) i_hit_list (
        .clk(clk),
        .wr_en(hit_bus.write_en),
        .wr_addr(hit_bus.index[hit_addr_w-1:0]),
        .wr_data(hit_bus.entry),
        .rd_addr(hit_rd_addr[hit_addr_w-1:0]),
        .rd_data(hit_rd_entry)
    );

    assign hit_rd_id = hit_rd_entry.sprite_id;
    assign hit_rd_row = hit_rd_entry.row;
    assign hit_rd_width = hit_rd_entry.width_select;
    assign hit_rd_terminator = hit_rd_entry.terminator;

endmodule

// ==== rtl/sprite_raster_collision.sv ====
`timescale 1ns/100ps

/*
  pipelined raster test, one sprite per cycle in ascending id order
  raster_y must stay stable from restart until finished
  hits past hit_list_size are dropped and then no terminator is written
*/
module sprite_raster_collision #(
    parameter int sprites_total = 48,
    parameter int hit_list_size = 32
) (
    input  logic clk,
    input  logic rst,
    input  logic restart,
    input  logic [sprite_eval_pkg::raster_y_w-1:0] raster_y,
    sprite_attr_if.scanner attr,
    hit_list_if.scanner hits,
    output logic finished,
    output logic [sprite_eval_pkg::hit_index_w-1:0] hit_count
);

    localparam int id_w = sprite_eval_pkg::sprite_id_w;
    localparam int y_w = sprite_eval_pkg::raster_y_w;
    localparam int idx_w = sprite_eval_pkg::hit_index_w;
    localparam logic [id_w-1:0] last_id = id_w'(sprites_total - 1);
    localparam logic [idx_w-1:0] list_cap = idx_w'(hit_list_size);

    // stage 0, read address to the attribute table
    logic issuing;
    logic [id_w-1:0] test_id;

    // stage 1, attributes back from the table
    logic s1_valid;
    logic [id_w-1:0] s1_id;
    logic [y_w-1:0] s1_diff;
    logic s1_hit;

    // stage 2, verdict with flip and width lined up
    logic s2_valid;
    logic s2_hit;
    logic [id_w-1:0] s2_id;
    sprite_eval_pkg::sprite_row_t s2_diff;
    sprite_eval_pkg::sprite_height_t s2_height;
    logic s2_flip;
    logic s2_width;
    logic [4:0] s2_flipped;
    sprite_eval_pkg::sprite_row_t s2_row;

    // write stage
    logic term_pending;
    logic term_done;
    logic wr_en;
    logic [idx_w-1:0] wr_index;
    logic [idx_w-1:0] wr_addr;
    sprite_eval_pkg::hit_entry_t wr_entry;
    sprite_eval_pkg::hit_entry_t next_entry;
    logic list_full;

    assign attr.test_id = test_id;

    always_ff @(posedge clk) begin
        if (rst) begin
            issuing <= 1'b0;
            test_id <= '0;
        end else if (restart) begin
            issuing <= 1'b1;
            test_id <= '0;
        end else if (issuing) begin
            if (test_id == last_id) begin
                issuing <= 1'b0;
            end else begin
                test_id <= test_id + 1'b1;
            end
        end
    end

    // modulo 512 distance from the sprite top, hit when inside the height
    always_comb begin
        s1_diff = raster_y - attr.attr.y;
        s1_hit = s1_diff < y_w'(attr.attr.height);
    end

    // valid bits, cleared on every new line
    always_ff @(posedge clk) begin
        if (rst || restart) begin
            s1_valid <= 1'b0;
            s2_valid <= 1'b0;
        end else begin
            s1_valid <= issuing;
            s2_valid <= s1_valid;
        end
    end

    always_ff @(posedge clk) begin
        s1_id <= test_id;
        s2_id <= s1_id;
        s2_hit <= s1_hit;
        // only a hit uses the row, and then the difference is below 16
        s2_diff <= s1_diff[3:0];
        s2_height <= attr.attr.height;
        s2_flip <= attr.attr.flip_y;
        s2_width <= attr.attr.width_select;
    end

    always_comb begin
        s2_flipped = s2_height - 5'd1 - {1'b0, s2_diff};
        s2_row = s2_flip ? s2_flipped[3:0] : s2_diff;
    end

    assign list_full = (wr_index == list_cap);

    always_comb begin
        if (term_pending) begin
            next_entry = sprite_eval_pkg::hit_terminator;
        end else begin
            next_entry.sprite_id = s2_id;
            next_entry.row = s2_row;
            next_entry.width_select = s2_width;
            next_entry.terminator = 1'b0;
        end
    end

    // wr_index already points at the next free slot
    always_ff @(posedge clk) begin
        if (rst || restart) begin
            wr_en <= 1'b0;
            wr_index <= '0;
            term_pending <= 1'b0;
            term_done <= 1'b0;
            finished <= 1'b0;
        end else begin
            wr_en <= 1'b0;
            term_done <= 1'b0;
            if (s2_valid && s2_hit && !list_full) begin
                wr_en <= 1'b1;
                wr_index <= wr_index + 1'b1;
            end
            if (s2_valid && s2_id == last_id) begin
                term_pending <= 1'b1;
            end
            // terminator goes one slot past the last hit, not counted
            if (term_pending) begin
                term_pending <= 1'b0;
                term_done <= 1'b1;
                if (!list_full) begin
                    wr_en <= 1'b1;
                end
            end
            if (term_done) begin
                finished <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        wr_addr <= wr_index;
        wr_entry <= next_entry;
    end

    assign hits.write_en = wr_en;
    assign hits.index = wr_addr;
    assign hits.entry = wr_entry;
    assign hit_count = wr_index;

endmodule

// ==== rtl/sprite_table_ram.sv ====
`timescale 1ns/100ps

/*
  one write port, one read port, registered read with one cycle latency
  a read of the address written in the same cycle returns the old entry
  contents are undefined after power up
*/
module sprite_table_ram #(
    parameter type entry_t = logic [15:0],
    parameter int depth = 256,
    localparam int addr_w = (depth > 1) ? $clog2(depth) : 1
) (
    input  logic clk,
    input  logic wr_en,
    input  logic [addr_w-1:0] wr_addr,
    input  entry_t wr_data,
    input  logic [addr_w-1:0] rd_addr,
    output entry_t rd_data
);

    entry_t mem [depth];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // read port
    always_ff @(posedge clk) begin
        rd_data <= mem[rd_addr];
    end

endmodule

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f sim.f --top-module tb_sprite_line_eval -o tb_sim
./obj_dir/tb_sim > sim.log 2>&1
cat sim.log

if grep -qx "sim passed" sim.log; then
    exit 0
else
    exit 1
fi

// ==== sim.f ====
rtl/sprite_eval_pkg.sv
rtl/sprite_attr_if.sv
rtl/hit_list_if.sv
rtl/sprite_table_ram.sv
rtl/sprite_raster_collision.sv
rtl/line_eval_ctrl.sv
rtl/sprite_line_eval_top.sv
dv/tb_sprite_line_eval.sv
